// File: Makefile
TOP = scanLink_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+verilog
verilog/scanPkg.sv
verilog/linkPkg.sv
verilog/scanner.sv
verilog/linkArbiter.sv
verilog/serialTx.sv
verilog/scanLink.sv
testbench/scanLink_checker.sv
testbench/scanLink_tb.sv

// File: testbench/scanLink_checker.sv
`timescale 1ns/1ns
`default_nettype none

module scanLink_checker (
	input logic        clk,
	input logic        rst,
	input logic        req,
	input logic        ack,
	input logic [15:0] payload, // hasData, code and data of the pending frame
	input logic        ackOther,
	input logic        start,
	input logic        busy
);

	reqHeld: assert property (@(posedge clk) disable iff (rst)
		(req && !ack) |=> (req && $stable(payload)))
		else $error("Request or its frame changed before the acknowledge");

	ackNeedsReq: assert property (@(posedge clk) disable iff (rst) ack |-> req)
		else $error("Acknowledge without a pending request");

	reqDrops: assert property (@(posedge clk) disable iff (rst) ack |=> !req)
		else $error("Request still high the cycle after its acknowledge");

	oneAck: assert property (@(posedge clk) disable iff (rst) !(ack && ackOther))
		else $error("Both sources acknowledged in the same cycle");

	startIdle: assert property (@(posedge clk) disable iff (rst) !(start && busy))
		else $error("Transmitter started while still busy");

endmodule

bind scanner scanLink_checker u_reqChk (
	.clk(clk), .rst(rst), .req(frameReq), .ack(frameAck),
	.payload({frameHasData, frameCode, frameData}),
	.ackOther(1'b0), .start(1'b0), .busy(1'b0)
);

bind linkArbiter scanLink_checker u_arbChk (
	.clk(clk), .rst(rst), .req(req0), .ack(ack0),
	.payload({hasData0, code0, data0}),
	.ackOther(ack1), .start(txStart), .busy(txBusy)
);

bind serialTx scanLink_checker u_txChk (
	.clk(clk), .rst(rst), .req(1'b0), .ack(1'b0), .payload(16'h0000),
	.ackOther(1'b0), .start(txStart), .busy(txBusy)
);

`default_nettype wire

// File: testbench/scanLink_tb.sv
`timescale 1ns/1ns
`default_nettype none

module scanLink_tb;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_SCANS = 40; // Watchdog budget in scans
	localparam int CYCLES_PER_SCAN = 400;
	localparam int TOTAL_SCANS = 32; // Directed and random together
	localparam int QUIET_CYCLES = 60;
	localparam int HOLD_CYCLES = 200;

	logic clk;
	logic rst;
	logic start0;
	logic start1;
	logic downlinkReady;
	logic [7:0] sample0;
	logic [7:0] sample1;
	logic dataOut;
	logic clkOut;
	logic frameSync;

	logic [31:0] rngState;
	int expWord[2][256]; // {hasData, data, header} per expected frame
	logic [7:0] expWr[2];
	logic [7:0] expRd[2];
	int scanCount[2]; // Scans started per source
	int rxCount[2];
	int dataSeen[2]; // Data frames received per source
	logic [15:0] rxBits;
	int rxLen;

	scanLink u_dut (
		.clk(clk), .rst(rst), .start0(start0), .start1(start1),
		.downlinkReady(downlinkReady), .sample0(sample0), .sample1(sample1),
		.dataOut(dataOut), .clkOut(clkOut), .frameSync(frameSync)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Xorshift32
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkEq(input int actual, input int expected, input string what);
		if (actual != expected) begin
			failRun($sformatf("MISMATCH at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	function automatic int frameWord(input logic src, input logic [6:0] code,
		input logic hasData, input logic [7:0] data);
		return int'({15'd0, hasData, data, src, code});
	endfunction

	function automatic logic scanIdle(input logic src);
		return scanCount[src] == dataSeen[src];
	endfunction

	task automatic pushFrame(input logic src, input int word);
		expWord[src][expWr[src]] = word;
		expWr[src] = expWr[src] + 8'd1;
	endtask

	// New sample, four expected frames, one start pulse
	task automatic startScan(input logic src);
		logic [31:0] rnd;
		logic [7:0] value;
		logic [7:0] sum9;
		rnd = nextRandom();
		value = rnd[15:8];
		sum9 = 8'((9 * int'(value)) % 256); // Nine equal samples
		pushFrame(src, frameWord(src, 7'd2, 1'b0, 8'd0));
		pushFrame(src, frameWord(src, 7'd3, 1'b0, 8'd0));
		pushFrame(src, frameWord(src, 7'd4, 1'b0, 8'd0));
		pushFrame(src, frameWord(src, 7'd7, 1'b1, sum9));
		if (src) begin
			sample1 = value;
			start1 = 1'b1;
		end else begin
			sample0 = value;
			start0 = 1'b1;
		end
		scanCount[src] = scanCount[src] + 1;
	endtask

	task automatic takeFrame();
		logic [7:0] hdr;
		logic src;
		int want;
		hdr = (rxLen == 16) ? rxBits[7:0] : rxBits[15:8];
		src = hdr[7];
		if (expRd[src] == expWr[src]) begin
			failRun($sformatf("Unexpected frame with header %02h from source %0d", hdr, src));
		end else begin
			want = expWord[src][expRd[src]];
			expRd[src] = expRd[src] + 8'd1;
			checkEq(int'(hdr), want & 255, "header byte");
			checkEq(rxLen, (want >> 16) * 8 + 8, "frame length in strobed bits");
			if ((want >> 16) == 1) begin
				checkEq(int'(rxBits[15:8]), (want >> 8) & 255, "data byte of the data frame");
				dataSeen[src] <= dataSeen[src] + 1;
			end
			rxCount[src] <= rxCount[src] + 1;
		end
	endtask

	// Deframer, samples mid cycle
	always @(negedge clk) begin
		if (rst) begin
			rxLen = 0;
			rxBits = '0;
			expRd[0] = '0;
			expRd[1] = '0;
			rxCount[0] <= 0;
			rxCount[1] <= 0;
			dataSeen[0] <= 0;
			dataSeen[1] <= 0;
		end else if (clkOut) begin
			checkEq(int'(frameSync), int'(rxLen == 0), "frameSync only on the first bit");
			if (rxLen >= 16) begin
				failRun("Frame ran past 16 bits without a gap");
			end else begin
				rxBits = {dataOut, rxBits[15:1]}; // LSB first
				rxLen = rxLen + 1;
			end
		end else if (rxLen != 0) begin
			takeFrame(); // Strobes stopped, frame complete
			rxLen = 0;
		end
	end

	initial begin
		#(NUM_SCANS * CYCLES_PER_SCAN * CLK_PERIOD);
		failRun("Watchdog timeout, the scans did not complete in time");
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start0 = 1'b0;
		start1 = 1'b0;
		downlinkReady = 1'b0;
		sample0 = '0;
		sample1 = '0;
		rngState = 32'd31;
		expWr[0] = '0;
		expWr[1] = '0;
		scanCount[0] = 0;
		scanCount[1] = 0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		// Line stays quiet with nothing started
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			checkEq(int'(clkOut), 0, "clkOut before any start");
			checkEq(int'(frameSync), 0, "frameSync before any start");
		end

		// Source 0 alone parks in standby
		startScan(1'b0);
		@(negedge clk);
		start0 = 1'b0;
		while (rxCount[0] < 3) @(negedge clk);
		repeat (HOLD_CYCLES) @(negedge clk);
		checkEq(rxCount[0], 3, "source 0 frames while held in standby");

		// Partner half fill releases it
		startScan(1'b1);
		@(negedge clk);
		start1 = 1'b0;
		while (dataSeen[0] < 1) @(negedge clk);

		// Source 1 now waits with an idle partner
		while (rxCount[1] < 3) @(negedge clk);
		repeat (HOLD_CYCLES) @(negedge clk);
		checkEq(rxCount[1], 3, "source 1 frames while held in standby");
		downlinkReady = 1'b1;
		while (dataSeen[1] < 1) @(negedge clk);

		// Random overlapping scans on both sources
		while ((scanCount[0] + scanCount[1] < TOTAL_SCANS) ||
			(dataSeen[0] + dataSeen[1] < scanCount[0] + scanCount[1])) begin
			@(negedge clk);
			start0 = 1'b0;
			start1 = 1'b0;
			if ((nextRandom() & 32'h7) == 0) begin
				downlinkReady = ~downlinkReady;
			end
			if (scanCount[0] + scanCount[1] < TOTAL_SCANS) begin
				if (scanIdle(1'b0) && (nextRandom() & 32'hF) == 0) begin
					startScan(1'b0);
				end
				if (scanIdle(1'b1) && (nextRandom() & 32'hF) == 0) begin
					startScan(1'b1);
				end
			end
		end
		start0 = 1'b0;
		start1 = 1'b0;
		repeat (20) @(negedge clk);

		if (expRd[0] == expWr[0] && expRd[1] == expWr[1]) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			failRun("Some expected frames never arrived");
		end
	end

endmodule

`default_nettype wire

// File: verilog/linkArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module linkArbiter
	import linkPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      req0,
	input  logic      req1,
	input  logic      hasData0,
	input  logic      hasData1,
	input  cmdCode_t  code0,
	input  cmdCode_t  code1,
	input  linkByte_t data0,
	input  linkByte_t data1,
	input  logic      txBusy,
	output logic      ack0,
	output logic      ack1,
	output logic      txStart,
	output logic      txHasData,
	output linkByte_t txHeader,
	output linkByte_t txData
);

	sourceId_t lastSrc; // Source served most recently
	sourceId_t grantSrc;
	logic grantValid;

	// Grant only with the transmitter idle and no start in flight
	always_comb begin
		grantValid = 1'b0;
		grantSrc = 1'b0;
		if (!txBusy && !txStart) begin
			if (req0 && req1) begin
				grantValid = 1'b1;
				grantSrc = ~lastSrc; // Take turns
			end else if (req0) begin
				grantValid = 1'b1;
				grantSrc = 1'b0;
			end else if (req1) begin
				grantValid = 1'b1;
				grantSrc = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack0 <= 1'b0;
			ack1 <= 1'b0;
			txStart <= 1'b0;
			lastSrc <= 1'b1; // Source 0 wins the first tie
		end else begin
			ack0 <= grantValid && (grantSrc == 1'b0);
			ack1 <= grantValid && (grantSrc == 1'b1);
			txStart <= grantValid;
			if (grantValid) begin
				lastSrc <= grantSrc;
			end
		end
	end

	// Frame registered for the transmitter alongside txStart
	always_ff @(posedge clk) begin
		if (grantValid) begin
			txHeader <= makeHeader(grantSrc, grantSrc ? code1 : code0);
			txHasData <= grantSrc ? hasData1 : hasData0;
			txData <= grantSrc ? data1 : data0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/linkPkg.sv
`default_nettype none

package linkPkg;

	// Command codes, low seven bits of a header byte
	typedef enum logic [6:0] {
		CMD_READY = 7'd2,
		CMD_START = 7'd3,
		CMD_FULL = 7'd4,
		CMD_DATA = 7'd7
	} cmdCode_t;

	typedef logic [7:0] linkByte_t;
	typedef logic sourceId_t; // Scanner index

	// Source id on bit 7, code below it
	function automatic linkByte_t makeHeader(input sourceId_t src, input cmdCode_t code);
		return {src, code};
	endfunction

endpackage

`default_nettype wire

// File: verilog/scanLink.sv
`timescale 1ns/1ns
`default_nettype none

module scanLink
	import scanPkg::*;
	import linkPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    start0,
	input  logic    start1,
	input  logic    downlinkReady,
	input  sample_t sample0,
	input  sample_t sample1,
	output logic    dataOut,
	output logic    clkOut,
	output logic    frameSync
);

	fillLevel_t fill0;
	fillLevel_t fill1;
	logic req0;
	logic req1;
	logic hasData0;
	logic hasData1;
	logic ack0;
	logic ack1;
	cmdCode_t code0;
	cmdCode_t code1;
	linkByte_t data0;
	linkByte_t data1;
	logic txStart;
	logic txBusy;
	logic txHasData;
	linkByte_t txHeader;
	linkByte_t txData;

	// Arbiter port 0, source id 0
	scanner u_scan0 (
		.clk(clk), .rst(rst), .start(start0), .downlinkReady(downlinkReady),
		.sampleIn(sample0), .partnerFill(fill1), .frameAck(ack0),
		.fill(fill0), .frameReq(req0), .frameHasData(hasData0),
		.frameCode(code0), .frameData(data0)
	);

	scanner u_scan1 (
		.clk(clk), .rst(rst), .start(start1), .downlinkReady(downlinkReady),
		.sampleIn(sample1), .partnerFill(fill0), .frameAck(ack1),
		.fill(fill1), .frameReq(req1), .frameHasData(hasData1),
		.frameCode(code1), .frameData(data1)
	);

	linkArbiter u_arb (
		.clk(clk), .rst(rst),
		.req0(req0), .req1(req1), .hasData0(hasData0), .hasData1(hasData1),
		.code0(code0), .code1(code1), .data0(data0), .data1(data1),
		.txBusy(txBusy), .ack0(ack0), .ack1(ack1), .txStart(txStart),
		.txHasData(txHasData), .txHeader(txHeader), .txData(txData)
	);

	serialTx u_tx (
		.clk(clk), .rst(rst), .txStart(txStart), .txHasData(txHasData),
		.txHeader(txHeader), .txData(txData), .txBusy(txBusy),
		.dataOut(dataOut), .clkOut(clkOut), .frameSync(frameSync)
	);

endmodule

`default_nettype wire

// File: verilog/scanPkg.sv
`default_nettype none

package scanPkg;

	localparam int FILL_W = 4; // Enough for nine samples
	localparam int SAMPLE_W = 8;

	// Scanner FSM states
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		STANDBY,
		TRANSFER
	} scanState_t;

	typedef logic [FILL_W-1:0] fillLevel_t; // Samples held in the buffer
	typedef logic [SAMPLE_W-1:0] sample_t; // Also used for the running sum

endpackage

`default_nettype wire

// File: verilog/scan_macros.svh
`ifndef SCAN_MACROS_SVH
`define SCAN_MACROS_SVH

`default_nettype none

// Slow tick period in clk cycles
`define SLOW_DIV 8

// Fill milestones announced once per scan
`define FILL_READY 7
`define FILL_START 8
`define FILL_FULL 9

// Partner fill that releases a scanner from standby
`define FILL_HALF 5

`default_nettype wire

`endif

// File: verilog/scanner.sv
`timescale 1ns/1ns
`include "scan_macros.svh"
`default_nettype none

module scanner
	import scanPkg::*;
	import linkPkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       downlinkReady,
	input  sample_t    sampleIn,
	input  fillLevel_t partnerFill,
	input  logic       frameAck,
	output fillLevel_t fill,
	output logic       frameReq,
	output logic       frameHasData,
	output cmdCode_t   frameCode,
	output linkByte_t  frameData
);

	localparam int TICK_W = $clog2(`SLOW_DIV);

	scanState_t state;
	logic [TICK_W-1:0] tickCnt;
	logic tick;
	logic justFilled; // Fill moved on the previous edge
	logic isMilestone;
	logic partnerHalf;
	logic raiseMilestone;
	logic raiseData;
	cmdCode_t milestoneCode;
	sample_t sum;

	// Slow tick, free running from reset release
	always_ff @(posedge clk) begin
		if (rst) begin
			tickCnt <= '0;
		end else if (tick) begin
			tickCnt <= '0;
		end else begin
			tickCnt <= tickCnt + 1'b1;
		end
	end

	assign tick = (tickCnt == TICK_W'(`SLOW_DIV - 1));

	// Map the current fill to its milestone command
	always_comb begin
		isMilestone = 1'b1;
		milestoneCode = CMD_READY;
		case (fill)
			fillLevel_t'(`FILL_READY): milestoneCode = CMD_READY;
			fillLevel_t'(`FILL_START): milestoneCode = CMD_START;
			fillLevel_t'(`FILL_FULL): milestoneCode = CMD_FULL;
			default: isMilestone = 1'b0;
		endcase
	end

	assign partnerHalf = (partnerFill >= fillLevel_t'(`FILL_HALF));
	assign raiseMilestone = (state == ACTIVE) && justFilled && isMilestone;
	assign raiseData = (state == TRANSFER) && !frameReq;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			fill <= '0;
			sum <= '0;
			frameReq <= 1'b0;
			justFilled <= 1'b0;
		end else begin
			justFilled <= 1'b0;
			if (frameAck) begin
				frameReq <= 1'b0; // Drops the cycle after the ack
			end
			case (state)
				IDLE: begin
					if (start) begin
						state <= ACTIVE;
					end
				end
				ACTIVE: begin
					// A pending request holds off sampling
					if (tick && !frameReq && fill < fillLevel_t'(`FILL_FULL)) begin
						fill <= fill + 1'b1;
						sum <= sum + sampleIn;
						justFilled <= 1'b1;
					end
					if (raiseMilestone) begin
						frameReq <= 1'b1;
					end
					if (frameAck && frameCode == CMD_FULL) begin
						state <= downlinkReady ? TRANSFER : STANDBY;
					end
				end
				STANDBY: begin
					if (downlinkReady || partnerHalf) begin
						state <= TRANSFER;
					end
				end
				TRANSFER: begin
					if (frameAck) begin
						state <= IDLE; // Buffer handed off
						fill <= '0;
						sum <= '0;
					end else if (raiseData) begin
						frameReq <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Frame contents, loaded together with the request
	always_ff @(posedge clk) begin
		if (raiseMilestone) begin
			frameCode <= milestoneCode;
			frameHasData <= 1'b0;
			frameData <= '0;
		end else if (raiseData) begin
			frameCode <= CMD_DATA;
			frameHasData <= 1'b1;
			frameData <= sum; // 8-bit wrap of the nine samples
		end
	end

endmodule

`default_nettype wire

// File: verilog/serialTx.sv
`timescale 1ns/1ns
`default_nettype none

module serialTx
	import linkPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      txStart,
	input  logic      txHasData,
	input  linkByte_t txHeader,
	input  linkByte_t txData,
	output logic      txBusy,
	output logic      dataOut,
	output logic      clkOut,
	output logic      frameSync
);

	localparam int BYTE_W = $bits(linkByte_t);
	localparam int FRAME_W = 2 * BYTE_W; // Header plus data byte
	localparam int CNT_W = $clog2(FRAME_W + 1);

	logic [FRAME_W-1:0] shiftReg;
	logic [CNT_W-1:0] bitsLeft;
	logic firstBit; // Header bit 0 on the line

	always_ff @(posedge clk) begin
		if (rst) begin
			txBusy <= 1'b0;
			bitsLeft <= '0;
			firstBit <= 1'b0;
		end else if (txStart) begin
			txBusy <= 1'b1;
			bitsLeft <= txHasData ? CNT_W'(FRAME_W) : CNT_W'(BYTE_W);
			firstBit <= 1'b1;
		end else if (txBusy) begin
			firstBit <= 1'b0;
			bitsLeft <= bitsLeft - 1'b1;
			if (bitsLeft == CNT_W'(1)) begin
				txBusy <= 1'b0; // Last bit goes out this cycle
			end
		end
	end

	// LSB first, header ahead of data
	always_ff @(posedge clk) begin
		if (txStart) begin
			shiftReg <= {txData, txHeader};
		end else if (txBusy) begin
			shiftReg <= {1'b0, shiftReg[FRAME_W-1:1]};
		end
	end

	assign dataOut = txBusy & shiftReg[0];
	assign clkOut = txBusy; // One strobe per valid bit
	assign frameSync = txBusy & firstBit;

endmodule

`default_nettype wire
